/* hw/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry: 32 sets of 2 ways, one 8-byte word per line
`define CACHE_SETS      32
`define CACHE_SET_BITS  5
`define CACHE_TAG_BITS  56

// bus word and address width
`define CBUS_DATA_BITS  64

// addresses with this bit clear bypass the cache
`define UNCACHED_BIT    31

`endif

/* hw/cbus_pkg.sv */
`default_nettype none

`include "cache_settings.svh"

package cbus_pkg;

    // cached view of an address
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0] tag;
        logic [`CACHE_SET_BITS-1:0] set;
        logic [2:0]                 offset;
    } cache_addr_fields_t;

    // one bus address, read raw for forwarding or split for lookup
    typedef union packed {
        logic [`CBUS_DATA_BITS-1:0] raw;
        cache_addr_fields_t         fields;
    } cbus_addr_t;

endpackage

`default_nettype wire

/* hw/cbus_req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cbus_req_decode (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            mmu_valid,
    input  wire                            mmu_is_write,
    input  wire  [`CBUS_DATA_BITS-1:0]     mmu_addr,
    input  wire  [`CBUS_DATA_BITS/8-1:0]   mmu_strobe,
    input  wire  [`CBUS_DATA_BITS-1:0]     mmu_wdata,
    input  wire                            req_done,
    output logic                           req_valid,
    output logic                           req_is_write,
    output cbus_pkg::cbus_addr_t           req_addr,
    output logic                           req_cached,
    output logic [`CBUS_DATA_BITS-1:0]     req_mask,
    output logic [`CBUS_DATA_BITS-1:0]     req_wdata
);

    logic                         cooldown;
    logic                         capture;
    logic [`CBUS_DATA_BITS/8-1:0] strobe_q;

    // mmu still holds the old request while it sees ready, so skip one cycle
    assign capture = mmu_valid && !req_valid && !cooldown;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_valid <= 1'b0;
            cooldown  <= 1'b0;
        end else if (req_valid && req_done) begin
            req_valid <= 1'b0;
            cooldown  <= 1'b1;
        end else begin
            cooldown <= 1'b0;
            if (capture) begin
                req_valid <= 1'b1;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (capture) begin
            req_is_write <= mmu_is_write;
            req_addr.raw <= mmu_addr;
            strobe_q     <= mmu_strobe;
            req_wdata    <= mmu_wdata;
        end
    end

    // one strobe bit per byte lane
    always_comb begin
        for (int i = 0; i < `CBUS_DATA_BITS / 8; i++) begin
            req_mask[8*i +: 8] = {8{strobe_q[i]}};
        end
    end

    assign req_cached = req_addr.raw[`UNCACHED_BIT];

endmodule

`default_nettype wire

/* hw/cache_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_store (
    input  wire                         clk,
    input  wire                         reset,
    input  wire  [`CACHE_SET_BITS-1:0]  lookup_set,
    input  wire  [`CACHE_TAG_BITS-1:0]  lookup_tag,
    input  wire                         wr_en,
    input  wire                         wr_way,
    input  wire  [`CACHE_TAG_BITS-1:0]  wr_tag,
    input  wire  [`CBUS_DATA_BITS-1:0]  wr_data,
    input  wire                         wr_dirty,
    input  wire                         touch_en,
    input  wire                         touch_way,
    output logic                        hit,
    output logic                        hit_way,
    output logic [`CBUS_DATA_BITS-1:0]  rd_data,
    output logic                        victim_way,
    output logic                        victim_dirty,
    output logic [`CACHE_TAG_BITS-1:0]  victim_tag,
    output logic [`CBUS_DATA_BITS-1:0]  victim_data
);

    logic [`CACHE_SETS-1:0][1:0] valid_q;
    logic [`CACHE_SETS-1:0][1:0] dirty_q;
    // lru_q holds the way to replace next
    logic [`CACHE_SETS-1:0]      lru_q;
    logic [`CACHE_TAG_BITS-1:0]  tag_q  [0:`CACHE_SETS-1][0:1];
    logic [`CBUS_DATA_BITS-1:0]  data_q [0:`CACHE_SETS-1][0:1];

    logic hit0;
    logic hit1;

    // both ways compared in parallel
    assign hit0    = valid_q[lookup_set][0] && (tag_q[lookup_set][0] == lookup_tag);
    assign hit1    = valid_q[lookup_set][1] && (tag_q[lookup_set][1] == lookup_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1 && !hit0;
    assign rd_data = data_q[lookup_set][hit_way];

    // lowest invalid way first, else the lru way
    always_comb begin
        if (!valid_q[lookup_set][0]) begin
            victim_way = 1'b0;
        end else if (!valid_q[lookup_set][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[lookup_set];
        end
    end

    assign victim_dirty = valid_q[lookup_set][victim_way] && dirty_q[lookup_set][victim_way];
    assign victim_tag   = tag_q[lookup_set][victim_way];
    assign victim_data  = data_q[lookup_set][victim_way];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (wr_en) begin
                valid_q[lookup_set][wr_way] <= 1'b1;
                dirty_q[lookup_set][wr_way] <= wr_dirty;
            end
            // the other way becomes least recently used
            if (touch_en) begin
                lru_q[lookup_set] <= ~touch_way;
            end else if (wr_en) begin
                lru_q[lookup_set] <= ~wr_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[lookup_set][wr_way]  <= wr_tag;
            data_q[lookup_set][wr_way] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_ctrl (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           req_valid,
    input  wire                           req_is_write,
    input  wire  cbus_pkg::cbus_addr_t    req_addr,
    input  wire                           req_cached,
    input  wire  [`CBUS_DATA_BITS-1:0]    req_mask,
    input  wire  [`CBUS_DATA_BITS-1:0]    req_wdata,
    input  wire                           hit,
    input  wire                           hit_way,
    input  wire  [`CBUS_DATA_BITS-1:0]    rd_data,
    input  wire                           victim_way,
    input  wire                           victim_dirty,
    input  wire  [`CACHE_TAG_BITS-1:0]    victim_tag,
    input  wire  [`CBUS_DATA_BITS-1:0]    victim_data,
    input  wire                           mem_ready,
    input  wire                           mem_last,
    input  wire  [`CBUS_DATA_BITS-1:0]    mem_rdata,
    output logic                          req_done,
    output logic                          wr_en,
    output logic                          wr_way,
    output logic [`CACHE_TAG_BITS-1:0]    wr_tag,
    output logic [`CBUS_DATA_BITS-1:0]    wr_data,
    output logic                          wr_dirty,
    output logic                          touch_en,
    output logic                          touch_way,
    output logic                          mem_valid,
    output logic                          mem_is_write,
    output logic [`CBUS_DATA_BITS-1:0]    mem_addr,
    output logic [`CBUS_DATA_BITS/8-1:0]  mem_strobe,
    output logic [`CBUS_DATA_BITS-1:0]    mem_wdata,
    output logic                          mmu_ready,
    output logic                          mmu_last,
    output logic [`CBUS_DATA_BITS-1:0]    mmu_rdata
);

    localparam logic [2:0] S_IDLE        = 3'd0;
    localparam logic [2:0] S_REFILL_WAIT = 3'd1;
    localparam logic [2:0] S_WB_WAIT     = 3'd2;
    localparam logic [2:0] S_FILL        = 3'd3;
    localparam logic [2:0] S_DIRECT_WAIT = 3'd4;

    logic [2:0]                   state;
    logic                         mem_done;
    logic [`CBUS_DATA_BITS-1:0]   fill_word;
    logic [`CBUS_DATA_BITS-1:0]   fill_data;
    logic [`CBUS_DATA_BITS/8-1:0] req_strobe;

    function automatic logic [`CBUS_DATA_BITS-1:0] merge_bytes(
        input logic [`CBUS_DATA_BITS-1:0] base,
        input logic [`CBUS_DATA_BITS-1:0] wdata,
        input logic [`CBUS_DATA_BITS-1:0] mask
    );
        merge_bytes = (wdata & mask) | (base & ~mask);
    endfunction

    // single-beat bus, so every ready is also the last beat
    assign mem_done  = mem_ready && mem_last;
    assign mmu_last  = mmu_ready;
    assign fill_data = req_is_write ? merge_bytes(fill_word, req_wdata, req_mask) : fill_word;

    // recover the byte strobe for uncached forwarding
    always_comb begin
        for (int i = 0; i < `CBUS_DATA_BITS / 8; i++) begin
            req_strobe[i] = req_mask[8*i];
        end
    end

    // store writes and request completion
    always_comb begin
        req_done  = 1'b0;
        wr_en     = 1'b0;
        wr_way    = hit_way;
        wr_tag    = req_addr.fields.tag;
        wr_data   = merge_bytes(rd_data, req_wdata, req_mask);
        wr_dirty  = 1'b1;
        touch_en  = 1'b0;
        touch_way = hit_way;
        case (state)
            S_IDLE: begin
                if (req_valid && req_cached && hit) begin
                    req_done = 1'b1;
                    touch_en = 1'b1;
                    wr_en    = req_is_write;
                end
            end
            S_FILL: begin
                req_done = 1'b1;
                wr_en    = 1'b1;
                wr_way   = victim_way;
                wr_data  = fill_data;
                wr_dirty = req_is_write;
            end
            S_DIRECT_WAIT: begin
                req_done = mem_done;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            mem_valid <= 1'b0;
            mmu_ready <= 1'b0;
        end else begin
            mmu_ready <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        if (!req_cached) begin
                            mem_valid <= 1'b1;
                            state     <= S_DIRECT_WAIT;
                        end else if (hit) begin
                            mmu_ready <= 1'b1;
                        end else begin
                            mem_valid <= 1'b1;
                            state     <= S_REFILL_WAIT;
                        end
                    end
                end
                S_REFILL_WAIT: begin
                    if (mem_done) begin
                        mem_valid <= 1'b0;
                        state     <= victim_dirty ? S_WB_WAIT : S_FILL;
                    end
                end
                S_WB_WAIT: begin
                    // valid low for one cycle between the read and the write-back
                    if (!mem_valid) begin
                        mem_valid <= 1'b1;
                    end else if (mem_done) begin
                        mem_valid <= 1'b0;
                        state     <= S_FILL;
                    end
                end
                S_FILL: begin
                    mmu_ready <= 1'b1;
                    state     <= S_IDLE;
                end
                S_DIRECT_WAIT: begin
                    if (mem_done) begin
                        mem_valid <= 1'b0;
                        mmu_ready <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // bus fields and response data
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (req_valid && !req_cached) begin
                    mem_is_write <= req_is_write;
                    mem_addr     <= req_addr.raw;
                    mem_strobe   <= req_strobe;
                    mem_wdata    <= req_wdata;
                end else if (req_valid && hit) begin
                    mmu_rdata <= rd_data;
                end else if (req_valid) begin
                    mem_is_write <= 1'b0;
                    mem_addr     <= {req_addr.fields.tag, req_addr.fields.set, 3'b000};
                    mem_strobe   <= '1;
                    mem_wdata    <= '0;
                end
            end
            S_REFILL_WAIT: begin
                // write-back fields, only sent when the victim is dirty
                if (mem_done) begin
                    fill_word    <= mem_rdata;
                    mem_is_write <= 1'b1;
                    mem_addr     <= {victim_tag, req_addr.fields.set, 3'b000};
                    mem_strobe   <= '1;
                    mem_wdata    <= victim_data;
                end
            end
            S_FILL: begin
                mmu_rdata <= fill_word;
            end
            S_DIRECT_WAIT: begin
                if (mem_done) begin
                    mmu_rdata <= mem_rdata;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/cached_cbus.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cached_cbus (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           mmu_valid,
    input  wire                           mmu_is_write,
    input  wire  [`CBUS_DATA_BITS-1:0]    mmu_addr,
    input  wire  [`CBUS_DATA_BITS/8-1:0]  mmu_strobe,
    input  wire  [`CBUS_DATA_BITS-1:0]    mmu_wdata,
    output logic                          mmu_ready,
    output logic                          mmu_last,
    output logic [`CBUS_DATA_BITS-1:0]    mmu_rdata,
    output logic                          mem_valid,
    output logic                          mem_is_write,
    output logic [`CBUS_DATA_BITS-1:0]    mem_addr,
    output logic [`CBUS_DATA_BITS/8-1:0]  mem_strobe,
    output logic [`CBUS_DATA_BITS-1:0]    mem_wdata,
    input  wire                           mem_ready,
    input  wire                           mem_last,
    input  wire  [`CBUS_DATA_BITS-1:0]    mem_rdata
);

    // decode stage to controller
    logic                        req_valid;
    logic                        req_is_write;
    cbus_pkg::cbus_addr_t        req_addr;
    logic                        req_cached;
    logic [`CBUS_DATA_BITS-1:0]  req_mask;
    logic [`CBUS_DATA_BITS-1:0]  req_wdata;
    logic                        req_done;

    // controller to store
    logic                        hit;
    logic                        hit_way;
    logic [`CBUS_DATA_BITS-1:0]  rd_data;
    logic                        victim_way;
    logic                        victim_dirty;
    logic [`CACHE_TAG_BITS-1:0]  victim_tag;
    logic [`CBUS_DATA_BITS-1:0]  victim_data;
    logic                        wr_en;
    logic                        wr_way;
    logic [`CACHE_TAG_BITS-1:0]  wr_tag;
    logic [`CBUS_DATA_BITS-1:0]  wr_data;
    logic                        wr_dirty;
    logic                        touch_en;
    logic                        touch_way;

    cbus_req_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .mmu_valid    (mmu_valid),
        .mmu_is_write (mmu_is_write),
        .mmu_addr     (mmu_addr),
        .mmu_strobe   (mmu_strobe),
        .mmu_wdata    (mmu_wdata),
        .req_done     (req_done),
        .req_valid    (req_valid),
        .req_is_write (req_is_write),
        .req_addr     (req_addr),
        .req_cached   (req_cached),
        .req_mask     (req_mask),
        .req_wdata    (req_wdata)
    );

    cache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_is_write (req_is_write),
        .req_addr     (req_addr),
        .req_cached   (req_cached),
        .req_mask     (req_mask),
        .req_wdata    (req_wdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .rd_data      (rd_data),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata),
        .req_done     (req_done),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_tag       (wr_tag),
        .wr_data      (wr_data),
        .wr_dirty     (wr_dirty),
        .touch_en     (touch_en),
        .touch_way    (touch_way),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_strobe   (mem_strobe),
        .mem_wdata    (mem_wdata),
        .mmu_ready    (mmu_ready),
        .mmu_last     (mmu_last),
        .mmu_rdata    (mmu_rdata)
    );

    // lookup always follows the registered request
    cache_store u_store (
        .clk          (clk),
        .reset        (reset),
        .lookup_set   (req_addr.fields.set),
        .lookup_tag   (req_addr.fields.tag),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_tag       (wr_tag),
        .wr_data      (wr_data),
        .wr_dirty     (wr_dirty),
        .touch_en     (touch_en),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .rd_data      (rd_data),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data)
    );

endmodule

`default_nettype wire

/* verif/cbus_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cbus_mem_model (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           mem_valid,
    input  wire                           mem_is_write,
    input  wire  [`CBUS_DATA_BITS-1:0]    mem_addr,
    input  wire  [`CBUS_DATA_BITS/8-1:0]  mem_strobe,
    input  wire  [`CBUS_DATA_BITS-1:0]    mem_wdata,
    output logic                          mem_ready,
    output logic                          mem_last,
    output logic [`CBUS_DATA_BITS-1:0]    mem_rdata,
    output int                            txn_count,
    output logic [`CBUS_DATA_BITS-1:0]    last_wr_addr,
    output logic [`CBUS_DATA_BITS-1:0]    last_wr_data
);

    // untouched words read back as their address mixed with this
    localparam logic [`CBUS_DATA_BITS-1:0] FILL_PATTERN = 64'ha5a5_5a5a_0f0f_f0f0;

    // only written words are stored
    logic [`CBUS_DATA_BITS-1:0] words [logic [`CBUS_DATA_BITS-1:0]];

    function automatic logic [`CBUS_DATA_BITS-1:0] read_word(
        input logic [`CBUS_DATA_BITS-1:0] addr
    );
        if (words.exists(addr)) begin
            return words[addr];
        end
        return addr ^ FILL_PATTERN;
    endfunction

    initial begin
        int                         delay;
        logic [`CBUS_DATA_BITS-1:0] aligned;
        logic [`CBUS_DATA_BITS-1:0] word;
        mem_ready    = 1'b0;
        mem_last     = 1'b0;
        mem_rdata    = '0;
        txn_count    = 0;
        last_wr_addr = '0;
        last_wr_data = '0;
        // seed the generator for the answer delays
        delay = $urandom(26);
        forever begin
            @(posedge clk);
            #1;
            mem_ready = 1'b0;
            mem_last  = 1'b0;
            if (!reset && mem_valid) begin
                // answer 1 to 4 cycles after the request shows up
                delay = $urandom % 4 + 1;
                for (int i = 1; i < delay; i++) begin
                    @(posedge clk);
                    #1;
                end
                aligned   = {mem_addr[`CBUS_DATA_BITS-1:3], 3'b000};
                word      = read_word(aligned);
                mem_rdata = word;
                if (mem_is_write) begin
                    for (int b = 0; b < `CBUS_DATA_BITS / 8; b++) begin
                        if (mem_strobe[b]) begin
                            word[8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                    words[aligned] = word;
                    last_wr_addr   = aligned;
                    last_wr_data   = word;
                end
                txn_count = txn_count + 1;
                mem_ready = 1'b1;
                mem_last  = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/cached_cbus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cached_cbus_tb;

    // words per trace line
    localparam int FIELDS       = 8;
    localparam int MAX_REQUESTS = 64;
    localparam int HIT_CYCLES   = 2;

    logic                          clk;
    logic                          reset;
    logic                          mmu_valid;
    logic                          mmu_is_write;
    logic [`CBUS_DATA_BITS-1:0]    mmu_addr;
    logic [`CBUS_DATA_BITS/8-1:0]  mmu_strobe;
    logic [`CBUS_DATA_BITS-1:0]    mmu_wdata;
    logic                          mmu_ready;
    logic                          mmu_last;
    logic [`CBUS_DATA_BITS-1:0]    mmu_rdata;
    logic                          mem_valid;
    logic                          mem_is_write;
    logic [`CBUS_DATA_BITS-1:0]    mem_addr;
    logic [`CBUS_DATA_BITS/8-1:0]  mem_strobe;
    logic [`CBUS_DATA_BITS-1:0]    mem_wdata;
    logic                          mem_ready;
    logic                          mem_last;
    logic [`CBUS_DATA_BITS-1:0]    mem_rdata;
    int                            txn_count;
    logic [`CBUS_DATA_BITS-1:0]    last_wr_addr;
    logic [`CBUS_DATA_BITS-1:0]    last_wr_data;

    logic [`CBUS_DATA_BITS-1:0]    trace_mem [0:FIELDS*MAX_REQUESTS-1];
    int                            num_requests;
    int                            error_count;
    int                            cycle_count = 0;
    int                            cycle_limit = 0;

    cached_cbus dut (
        .clk          (clk),
        .reset        (reset),
        .mmu_valid    (mmu_valid),
        .mmu_is_write (mmu_is_write),
        .mmu_addr     (mmu_addr),
        .mmu_strobe   (mmu_strobe),
        .mmu_wdata    (mmu_wdata),
        .mmu_ready    (mmu_ready),
        .mmu_last     (mmu_last),
        .mmu_rdata    (mmu_rdata),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_strobe   (mem_strobe),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata)
    );

    cbus_mem_model mem_model (
        .clk          (clk),
        .reset        (reset),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_strobe   (mem_strobe),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata),
        .txn_count    (txn_count),
        .last_wr_addr (last_wr_addr),
        .last_wr_data (last_wr_data)
    );

    always begin
        #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the DUT gave no response within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(
        input string                      name,
        input logic [`CBUS_DATA_BITS-1:0] got,
        input logic [`CBUS_DATA_BITS-1:0] expected
    );
        if (got !== expected) begin
            error_count = error_count + 1;
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic run_request(input int index);
        int    base;
        int    edges;
        int    start_count;
        int    errors_before;
        string op_name;
        string status;
        base          = index * FIELDS;
        errors_before = error_count;
        op_name       = trace_mem[base][0] ? "write" : "read";
        @(posedge clk);
        #1;
        // ready is a single-cycle pulse
        check_value("mmu_ready", 64'(mmu_ready), 64'd0);
        check_value("mmu_last", 64'(mmu_last), 64'd0);
        start_count  = txn_count;
        mmu_valid    = 1'b1;
        mmu_is_write = trace_mem[base][0];
        mmu_addr     = trace_mem[base+1];
        mmu_strobe   = trace_mem[base+2][`CBUS_DATA_BITS/8-1:0];
        mmu_wdata    = trace_mem[base+3];
        edges        = 0;
        while (!mmu_ready) begin
            @(posedge clk);
            #1;
            edges = edges + 1;
        end
        mmu_valid = 1'b0;
        check_value("mmu_last", 64'(mmu_last), 64'd1);
        check_value("mmu_rdata", mmu_rdata, trace_mem[base+4]);
        check_value("mem transactions", 64'(txn_count - start_count), trace_mem[base+5]);
        check_value("last write addr", last_wr_addr, trace_mem[base+6]);
        check_value("last write data", last_wr_data, trace_mem[base+7]);
        // no memory traffic means a hit
        if (trace_mem[base+5] == 64'd0) begin
            check_value("hit latency", 64'(edges), 64'(HIT_CYCLES));
        end
        if (error_count == errors_before) begin
            status = "ok";
        end else begin
            status = "mismatch";
        end
        $display("request %0d %s %h: %s", index, op_name, trace_mem[base+1], status);
    endtask

    initial begin
        string status;
        clk          = 1'b0;
        reset        = 1'b1;
        mmu_valid    = 1'b0;
        mmu_is_write = 1'b0;
        mmu_addr     = '0;
        mmu_strobe   = '0;
        mmu_wdata    = '0;
        error_count  = 0;
        num_requests = 0;
        for (int i = 0; i < FIELDS * MAX_REQUESTS; i++) begin
            trace_mem[i] = '1;
        end
        $readmemh("verif/cached_cbus_trace.txt", trace_mem);
        // op word is 0 or 1 and anything else ends the trace
        while (num_requests < MAX_REQUESTS && trace_mem[num_requests*FIELDS] <= 64'd1) begin
            num_requests = num_requests + 1;
        end
        cycle_limit = num_requests * 30 + 100;
        if (num_requests == 0) begin
            $display("The trace file holds no requests");
            error_count = error_count + 1;
        end

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // quiet bus after reset
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("mmu_ready", 64'(mmu_ready), 64'd0);
            check_value("mmu_last", 64'(mmu_last), 64'd0);
            check_value("mem_valid", 64'(mem_valid), 64'd0);
        end
        if (error_count == 0) begin
            status = "ok";
        end else begin
            status = "mismatch";
        end
        $display("idle after reset: %s", status);

        for (int r = 0; r < num_requests; r++) begin
            run_request(r);
        end

        $display("%0d requests run, %0d errors", num_requests, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/cached_cbus_trace.txt */
// op(0 read, 1 write) addr strobe wdata exp_rdata exp_mem_txns
//   exp_last_wr_addr exp_last_wr_data
0 0000000080001000 ff 0000000000000000 a5a55a5a8f0fe0f0 1 0000000000000000 0000000000000000
1 0000000080001000 0f 1122334455667788 a5a55a5a8f0fe0f0 0 0000000000000000 0000000000000000
0 0000000080001000 ff 0000000000000000 a5a55a5a55667788 0 0000000000000000 0000000000000000
0 0000000080002010 ff 0000000000000000 a5a55a5a8f0fd0e0 1 0000000000000000 0000000000000000
0 0000000080003010 ff 0000000000000000 a5a55a5a8f0fc0e0 1 0000000000000000 0000000000000000
0 0000000080002010 ff 0000000000000000 a5a55a5a8f0fd0e0 0 0000000000000000 0000000000000000
0 0000000080004010 ff 0000000000000000 a5a55a5a8f0fb0e0 1 0000000000000000 0000000000000000
0 0000000080002010 ff 0000000000000000 a5a55a5a8f0fd0e0 0 0000000000000000 0000000000000000
0 0000000080003010 ff 0000000000000000 a5a55a5a8f0fc0e0 1 0000000000000000 0000000000000000
1 0000000080005020 f0 deadbeefcafef00d a5a55a5a8f0fa0d0 1 0000000000000000 0000000000000000
0 0000000080006020 ff 0000000000000000 a5a55a5a8f0f90d0 1 0000000000000000 0000000000000000
0 0000000080007020 ff 0000000000000000 a5a55a5a8f0f80d0 2 0000000080005020 deadbeef8f0fa0d0
0 0000000080005020 ff 0000000000000000 deadbeef8f0fa0d0 1 0000000080005020 deadbeef8f0fa0d0
0 0000000000004008 ff 0000000000000000 a5a55a5a0f0fb0f8 1 0000000080005020 deadbeef8f0fa0d0
0 0000000000004008 ff 0000000000000000 a5a55a5a0f0fb0f8 1 0000000080005020 deadbeef8f0fa0d0
1 0000000000004008 3c 0123456789abcdef a5a55a5a0f0fb0f8 1 0000000000004008 a5a5456789abb0f8
0 0000000000004008 ff 0000000000000000 a5a5456789abb0f8 1 0000000000004008 a5a5456789abb0f8

/* verilog.f */
+incdir+hw
hw/cbus_pkg.sv
hw/cbus_req_decode.sv
hw/cache_store.sv
hw/cache_ctrl.sv
hw/cached_cbus.sv
verif/cbus_mem_model.sv
verif/cached_cbus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module cached_cbus_tb -o cached_cbus_sim -f verilog.f \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/cached_cbus_sim > sim.log 2>&1
cat sim.log

grep -q "^Simulation finished: PASS$" sim.log \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
